/* Makefile */
SIM  := obj_dir/Vriscv_lsu_tb
SRCS := $(shell cat build.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): build.f $(SRCS)
	verilator --binary --assert --timing --top-module riscv_lsu_tb -f build.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* build.f */
logic/riscv_lsu_pkg.sv
logic/riscv_lsu.sv
logic/riscv_lsu_dmem.sv
logic/riscv_lsu_clint_timer.sv
logic/riscv_lsu_wb_stage.sv
logic/riscv_lsu_mem_top.sv
sim/riscv_lsu_chk.sv
sim/riscv_lsu_tb.sv

/* logic/riscv_lsu.sv */
`timescale 1ns/100ps

module riscv_lsu (
  input  logic                               i_riscv_lsu_clk,
  input  logic                               i_riscv_lsu_rst,
  input  logic                               i_riscv_lsu_globstall,
  input  logic [riscv_lsu_pkg::XLEN-1:0]     i_riscv_lsu_address,      // rs1
  input  logic [riscv_lsu_pkg::XLEN-1:0]     i_riscv_lsu_alu_result,
  input  logic [1:0]                         i_riscv_lsu_lr,           // [1] lr, [0] size
  input  logic [1:0]                         i_riscv_lsu_sc,           // [1] sc, [0] size
  input  logic                               i_riscv_lsu_amo,
  input  logic                               i_riscv_lsu_dcache_wren,
  input  logic                               i_riscv_lsu_dcache_rden,
  input  logic                               i_riscv_lsu_goto_trap,    // from csr
  input  logic [1:0]                         i_riscv_lsu_return_trap,  // from csr
  input  logic                               i_riscv_lsu_misalignment, // no misaligned traps yet
  output logic                               o_riscv_lsu_dcache_wren,
  output logic                               o_riscv_lsu_dcache_rden,
  output logic [riscv_lsu_pkg::XLEN-1:0]     o_riscv_lsu_phy_address,
  output logic [riscv_lsu_pkg::XLEN-1:0]     o_riscv_lsu_sc_rdvalue,
  output logic                               o_riscv_lsu_timer_wren,
  output logic                               o_riscv_lsu_timer_rden,
  output riscv_lsu_pkg::timer_regsel_e       o_riscv_lsu_timer_regsel
);

  import riscv_lsu_pkg::*;

  // one-hot operation code
  typedef enum logic [4:0] {
    OP_NONE  = 5'b00000,
    OP_READ  = 5'b10000,
    OP_WRITE = 5'b01000,
    OP_LR    = 5'b00100,
    OP_SC    = 5'b00010,
    OP_AMO   = 5'b00001
  } lsu_op_e;

  lsu_op_e         op;
  logic            trap_active;
  logic            is_timer;     // address hits mtime or mtimecmp
  logic            sc_success;
  logic [XLEN-1:0] reserv_addr;
  logic            reserv_size;  // size bit of the lr
  logic            reserv_valid;

  assign trap_active = i_riscv_lsu_goto_trap || (|i_riscv_lsu_return_trap);

  assign is_timer = (i_riscv_lsu_alu_result == CLINT_MTIME) ||
                    (i_riscv_lsu_alu_result == CLINT_MTIMECMP);

  // atomics win over the plain strobes
  always_comb
  begin
    if (i_riscv_lsu_lr[1])
      op = OP_LR;
    else if (i_riscv_lsu_sc[1])
      op = OP_SC;
    else if (i_riscv_lsu_amo)
      op = OP_AMO;
    else if (i_riscv_lsu_dcache_wren)
      op = OP_WRITE;
    else if (i_riscv_lsu_dcache_rden)
      op = OP_READ;
    else
      op = OP_NONE;
  end

  assign sc_success = i_riscv_lsu_sc[1] &&
                      reserv_valid &&
                      (i_riscv_lsu_address == reserv_addr) &&
                      (reserv_size == i_riscv_lsu_sc[0]) &&
                      !trap_active;

  // reservation valid bit
  always_ff @(posedge i_riscv_lsu_clk or posedge i_riscv_lsu_rst)
  begin
    if (i_riscv_lsu_rst)
    begin
      reserv_valid <= 1'b0;
    end
    else if (!i_riscv_lsu_globstall)
    begin
      if (i_riscv_lsu_lr[1] && !trap_active)
        reserv_valid <= 1'b1;
      else if (i_riscv_lsu_sc[1])
        reserv_valid <= 1'b0; // any sc drops it
    end
  end

  // reserved address and size
  always_ff @(posedge i_riscv_lsu_clk)
  begin
    if (!i_riscv_lsu_globstall && i_riscv_lsu_lr[1] && !trap_active)
    begin
      reserv_addr <= i_riscv_lsu_address;
      reserv_size <= i_riscv_lsu_lr[0];
    end
  end

  // 0 on success, 1 on failure
  assign o_riscv_lsu_sc_rdvalue = {{(XLEN-1){1'b0}}, i_riscv_lsu_sc[1] && !sc_success};

  // data memory strobes and address
  always_comb
  begin
    o_riscv_lsu_dcache_rden = 1'b0;
    o_riscv_lsu_dcache_wren = 1'b0;
    o_riscv_lsu_phy_address = '0;
    case (op)
      OP_READ:
      begin
        o_riscv_lsu_dcache_rden = !trap_active && !is_timer;
        o_riscv_lsu_phy_address = i_riscv_lsu_alu_result;
      end
      OP_WRITE:
      begin
        o_riscv_lsu_dcache_wren = !trap_active && !is_timer;
        o_riscv_lsu_phy_address = i_riscv_lsu_alu_result;
      end
      OP_LR, OP_AMO:
      begin
        o_riscv_lsu_dcache_rden = !trap_active;
        o_riscv_lsu_phy_address = i_riscv_lsu_address;
      end
      OP_SC:
      begin
        o_riscv_lsu_dcache_wren = sc_success;
        o_riscv_lsu_phy_address = i_riscv_lsu_address;
      end
      default:
      begin
        o_riscv_lsu_dcache_rden = 1'b0;
      end
    endcase
  end

  // plain loads and stores to the clint go to the timer
  assign o_riscv_lsu_timer_wren = is_timer && (op == OP_WRITE) && !trap_active;
  assign o_riscv_lsu_timer_rden = is_timer && (op == OP_READ) && !trap_active;

  always_comb
  begin
    case (i_riscv_lsu_alu_result)
      CLINT_MTIME:    o_riscv_lsu_timer_regsel = TREG_MTIME;
      CLINT_MTIMECMP: o_riscv_lsu_timer_regsel = TREG_MTIMECMP;
      default:        o_riscv_lsu_timer_regsel = TREG_NONE;
    endcase
  end

endmodule

/* logic/riscv_lsu_clint_timer.sv */
`timescale 1ns/100ps

module riscv_lsu_clint_timer (
  input  logic                           i_riscv_lsu_clk,
  input  logic                           i_riscv_lsu_rst,
  input  logic                           i_riscv_lsu_timer_wren,
  input  logic                           i_riscv_lsu_timer_rden,
  input  riscv_lsu_pkg::timer_regsel_e   i_riscv_lsu_timer_regsel,
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_riscv_lsu_timer_wdata,
  output logic [riscv_lsu_pkg::XLEN-1:0] o_riscv_lsu_timer_rdata,
  output logic                           o_riscv_lsu_timer_irq
);

  import riscv_lsu_pkg::*;

  logic [XLEN-1:0] mtime;
  logic [XLEN-1:0] mtime_nxt;
  logic [XLEN-1:0] mtimecmp;
  logic            mtime_we;
  logic            mtimecmp_we;

  assign mtime_we    = i_riscv_lsu_timer_wren && (i_riscv_lsu_timer_regsel == TREG_MTIME);
  assign mtimecmp_we = i_riscv_lsu_timer_wren && (i_riscv_lsu_timer_regsel == TREG_MTIMECMP);

  // a write replaces the count, otherwise count up
  assign mtime_nxt = mtime_we ? i_riscv_lsu_timer_wdata : mtime + 1'b1;

  always_ff @(posedge i_riscv_lsu_clk or posedge i_riscv_lsu_rst)
  begin
    if (i_riscv_lsu_rst)
      mtime <= '0;
    else
      mtime <= mtime_nxt;
  end

  always_ff @(posedge i_riscv_lsu_clk or posedge i_riscv_lsu_rst)
  begin
    if (i_riscv_lsu_rst)
      mtimecmp <= '1;  // nothing pending out of reset
    else if (mtimecmp_we)
      mtimecmp <= i_riscv_lsu_timer_wdata;
  end

  // read returns mtime as it stands after this edge
  always_ff @(posedge i_riscv_lsu_clk or posedge i_riscv_lsu_rst)
  begin
    if (i_riscv_lsu_rst)
    begin
      o_riscv_lsu_timer_rdata <= '0;
    end
    else if (i_riscv_lsu_timer_rden)
    begin
      case (i_riscv_lsu_timer_regsel)
        TREG_MTIME:    o_riscv_lsu_timer_rdata <= mtime_nxt;
        TREG_MTIMECMP: o_riscv_lsu_timer_rdata <= mtimecmp;
        default:       o_riscv_lsu_timer_rdata <= '0;
      endcase
    end
  end

  // level interrupt, stays up until mtimecmp moves past mtime
  always_ff @(posedge i_riscv_lsu_clk or posedge i_riscv_lsu_rst)
  begin
    if (i_riscv_lsu_rst)
      o_riscv_lsu_timer_irq <= 1'b0;
    else
      o_riscv_lsu_timer_irq <= (mtime >= mtimecmp);
  end

endmodule

/* logic/riscv_lsu_dmem.sv */
`timescale 1ns/100ps

module riscv_lsu_dmem (
  input  logic                           i_riscv_lsu_clk,
  input  logic                           i_riscv_lsu_rst,
  input  logic                           i_riscv_lsu_dmem_wren,
  input  logic                           i_riscv_lsu_dmem_rden,
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_riscv_lsu_dmem_addr,  // byte address
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_riscv_lsu_dmem_wdata,
  output logic [riscv_lsu_pkg::XLEN-1:0] o_riscv_lsu_dmem_rdata
);

  import riscv_lsu_pkg::*;

  logic [XLEN-1:0]        mem [0:DMEM_DEPTH-1];
  logic [DMEM_ADDR_W-1:0] idx;

  // doubleword index, upper address bits are ignored
  assign idx = i_riscv_lsu_dmem_addr[DMEM_IDX_LSB +: DMEM_ADDR_W];

  // full doubleword write
  always_ff @(posedge i_riscv_lsu_clk)
  begin
    if (i_riscv_lsu_dmem_wren)
      mem[idx] <= i_riscv_lsu_dmem_wdata;
  end

  // registered read, holds the last word when idle
  always_ff @(posedge i_riscv_lsu_clk or posedge i_riscv_lsu_rst)
  begin
    if (i_riscv_lsu_rst)
    begin
      o_riscv_lsu_dmem_rdata <= '0;
    end
    else if (i_riscv_lsu_dmem_rden)
    begin
      o_riscv_lsu_dmem_rdata <= mem[idx];
    end
  end

endmodule

/* logic/riscv_lsu_mem_top.sv */
`timescale 1ns/100ps

module riscv_lsu_mem_top (
  input  logic                           i_riscv_lsu_clk,
  input  logic                           i_riscv_lsu_rst,
  input  logic                           i_riscv_lsu_globstall,
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_riscv_lsu_address,
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_riscv_lsu_alu_result,
  input  logic [1:0]                     i_riscv_lsu_lr,
  input  logic [1:0]                     i_riscv_lsu_sc,
  input  logic                           i_riscv_lsu_amo,
  input  logic                           i_riscv_lsu_dcache_wren,
  input  logic                           i_riscv_lsu_dcache_rden,
  input  logic                           i_riscv_lsu_goto_trap,
  input  logic [1:0]                     i_riscv_lsu_return_trap,
  input  logic                           i_riscv_lsu_misalignment,
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_riscv_lsu_store_data,
  output logic [riscv_lsu_pkg::XLEN-1:0] o_riscv_lsu_wb_data,
  output logic                           o_riscv_lsu_wb_valid,
  output logic                           o_riscv_lsu_timer_irq
);

  import riscv_lsu_pkg::*;

  logic            dcache_wren;
  logic            dcache_rden;
  logic [XLEN-1:0] phy_address;
  logic [XLEN-1:0] sc_rdvalue;
  logic            timer_wren;
  logic            timer_rden;
  timer_regsel_e   timer_regsel;
  logic [XLEN-1:0] dmem_rdata;
  logic [XLEN-1:0] timer_rdata;

  riscv_lsu riscv_lsu_inst (
    .i_riscv_lsu_clk          (i_riscv_lsu_clk),
    .i_riscv_lsu_rst          (i_riscv_lsu_rst),
    .i_riscv_lsu_globstall    (i_riscv_lsu_globstall),
    .i_riscv_lsu_address      (i_riscv_lsu_address),
    .i_riscv_lsu_alu_result   (i_riscv_lsu_alu_result),
    .i_riscv_lsu_lr           (i_riscv_lsu_lr),
    .i_riscv_lsu_sc           (i_riscv_lsu_sc),
    .i_riscv_lsu_amo          (i_riscv_lsu_amo),
    .i_riscv_lsu_dcache_wren  (i_riscv_lsu_dcache_wren),
    .i_riscv_lsu_dcache_rden  (i_riscv_lsu_dcache_rden),
    .i_riscv_lsu_goto_trap    (i_riscv_lsu_goto_trap),
    .i_riscv_lsu_return_trap  (i_riscv_lsu_return_trap),
    .i_riscv_lsu_misalignment (i_riscv_lsu_misalignment),
    .o_riscv_lsu_dcache_wren  (dcache_wren),
    .o_riscv_lsu_dcache_rden  (dcache_rden),
    .o_riscv_lsu_phy_address  (phy_address),
    .o_riscv_lsu_sc_rdvalue   (sc_rdvalue),
    .o_riscv_lsu_timer_wren   (timer_wren),
    .o_riscv_lsu_timer_rden   (timer_rden),
    .o_riscv_lsu_timer_regsel (timer_regsel)
  );

  riscv_lsu_dmem riscv_lsu_dmem_inst (
    .i_riscv_lsu_clk        (i_riscv_lsu_clk),
    .i_riscv_lsu_rst        (i_riscv_lsu_rst),
    .i_riscv_lsu_dmem_wren  (dcache_wren),
    .i_riscv_lsu_dmem_rden  (dcache_rden),
    .i_riscv_lsu_dmem_addr  (phy_address),
    .i_riscv_lsu_dmem_wdata (i_riscv_lsu_store_data),
    .o_riscv_lsu_dmem_rdata (dmem_rdata)
  );

  // store data also feeds the timer registers
  riscv_lsu_clint_timer riscv_lsu_clint_timer_inst (
    .i_riscv_lsu_clk          (i_riscv_lsu_clk),
    .i_riscv_lsu_rst          (i_riscv_lsu_rst),
    .i_riscv_lsu_timer_wren   (timer_wren),
    .i_riscv_lsu_timer_rden   (timer_rden),
    .i_riscv_lsu_timer_regsel (timer_regsel),
    .i_riscv_lsu_timer_wdata  (i_riscv_lsu_store_data),
    .o_riscv_lsu_timer_rdata  (timer_rdata),
    .o_riscv_lsu_timer_irq    (o_riscv_lsu_timer_irq)
  );

  riscv_lsu_wb_stage riscv_lsu_wb_stage_inst (
    .i_riscv_lsu_clk         (i_riscv_lsu_clk),
    .i_riscv_lsu_rst         (i_riscv_lsu_rst),
    .i_riscv_lsu_globstall   (i_riscv_lsu_globstall),
    .i_riscv_lsu_dcache_rden (dcache_rden),
    .i_riscv_lsu_timer_rden  (timer_rden),
    .i_riscv_lsu_sc_valid    (i_riscv_lsu_sc[1]),  // every sc returns a value
    .i_riscv_lsu_sc_rdvalue  (sc_rdvalue),
    .i_riscv_lsu_dmem_rdata  (dmem_rdata),
    .i_riscv_lsu_timer_rdata (timer_rdata),
    .o_riscv_lsu_wb_data     (o_riscv_lsu_wb_data),
    .o_riscv_lsu_wb_valid    (o_riscv_lsu_wb_valid)
  );

endmodule

/* logic/riscv_lsu_pkg.sv */
package riscv_lsu_pkg;

  // data and address width of the core
  localparam int XLEN = 64;

  // clint register map
  localparam logic [XLEN-1:0] CLINT_BASE     = 64'h0000_0000_0200_0000;
  localparam logic [XLEN-1:0] CLINT_MTIMECMP = CLINT_BASE + 64'h4000;
  localparam logic [XLEN-1:0] CLINT_MTIME    = CLINT_BASE + 64'hBFF8; // cycles since boot

  // data memory geometry
  localparam int DMEM_ADDR_W  = 8;                 // doubleword index width
  localparam int DMEM_IDX_LSB = 3;                 // skip byte offset in a doubleword
  localparam int DMEM_DEPTH   = 1 << DMEM_ADDR_W;  // 256 doublewords

  // which timer register an access targets
  typedef enum logic [1:0] {
    TREG_NONE     = 2'd0,
    TREG_MTIME    = 2'd1,
    TREG_MTIMECMP = 2'd2
  } timer_regsel_e;

endpackage

/* logic/riscv_lsu_wb_stage.sv */
`timescale 1ns/100ps

module riscv_lsu_wb_stage (
  input  logic                           i_riscv_lsu_clk,
  input  logic                           i_riscv_lsu_rst,
  input  logic                           i_riscv_lsu_globstall,
  input  logic                           i_riscv_lsu_dcache_rden,
  input  logic                           i_riscv_lsu_timer_rden,
  input  logic                           i_riscv_lsu_sc_valid,
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_riscv_lsu_sc_rdvalue,
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_riscv_lsu_dmem_rdata,
  input  logic [riscv_lsu_pkg::XLEN-1:0] i_riscv_lsu_timer_rdata,
  output logic [riscv_lsu_pkg::XLEN-1:0] o_riscv_lsu_wb_data,
  output logic                           o_riscv_lsu_wb_valid
);

  import riscv_lsu_pkg::*;

  logic            src_mem;
  logic            src_timer;
  logic            src_sc;
  logic            valid_q;
  logic [XLEN-1:0] sc_val;

  // result source, registered alongside the access stage
  always_ff @(posedge i_riscv_lsu_clk or posedge i_riscv_lsu_rst)
  begin
    if (i_riscv_lsu_rst)
    begin
      src_mem   <= 1'b0;
      src_timer <= 1'b0;
      src_sc    <= 1'b0;
      valid_q   <= 1'b0;
    end
    else if (i_riscv_lsu_globstall)
    begin
      valid_q <= 1'b0;  // sources hold
    end
    else
    begin
      src_mem   <= i_riscv_lsu_dcache_rden;
      src_timer <= i_riscv_lsu_timer_rden;
      src_sc    <= i_riscv_lsu_sc_valid;
      valid_q   <= i_riscv_lsu_dcache_rden || i_riscv_lsu_timer_rden || i_riscv_lsu_sc_valid;
    end
  end

  always_ff @(posedge i_riscv_lsu_clk)
  begin
    if (!i_riscv_lsu_globstall)
      sc_val <= i_riscv_lsu_sc_rdvalue;
  end

  // result select
  always_comb
  begin
    if (src_sc)
      o_riscv_lsu_wb_data = sc_val;
    else if (src_timer)
      o_riscv_lsu_wb_data = i_riscv_lsu_timer_rdata;
    else if (src_mem)
      o_riscv_lsu_wb_data = i_riscv_lsu_dmem_rdata;
    else
      o_riscv_lsu_wb_data = '0;
  end

  assign o_riscv_lsu_wb_valid = valid_q;

endmodule

/* sim/riscv_lsu_chk.sv */
`timescale 1ns/100ps

module riscv_lsu_chk (
  input logic                           i_riscv_lsu_clk,
  input logic                           i_riscv_lsu_rst,
  input logic                           i_riscv_lsu_goto_trap,
  input logic                           i_riscv_lsu_dcache_wren,
  input logic                           i_riscv_lsu_dcache_rden,
  input logic                           i_riscv_lsu_timer_wren,
  input logic                           i_riscv_lsu_timer_rden,
  input logic [riscv_lsu_pkg::XLEN-1:0] i_riscv_lsu_sc_rdvalue
);

  import riscv_lsu_pkg::*;

  logic dmem_strobe;
  logic timer_strobe;

  assign dmem_strobe  = i_riscv_lsu_dcache_wren || i_riscv_lsu_dcache_rden;
  assign timer_strobe = i_riscv_lsu_timer_wren || i_riscv_lsu_timer_rden;

  dmem_rw_excl: assert property (@(posedge i_riscv_lsu_clk) disable iff (i_riscv_lsu_rst)
    !(i_riscv_lsu_dcache_wren && i_riscv_lsu_dcache_rden))
  else $error("data memory read and write strobes are high together");

  route_excl: assert property (@(posedge i_riscv_lsu_clk) disable iff (i_riscv_lsu_rst)
    !(dmem_strobe && timer_strobe))
  else $error("timer and data memory strobes are high together");

  // a trap must squash the store
  trap_no_write: assert property (@(posedge i_riscv_lsu_clk) disable iff (i_riscv_lsu_rst)
    !(i_riscv_lsu_goto_trap && i_riscv_lsu_dcache_wren))
  else $error("data memory write while goto_trap is high");

  sc_value_bit: assert property (@(posedge i_riscv_lsu_clk) disable iff (i_riscv_lsu_rst)
    i_riscv_lsu_sc_rdvalue[XLEN-1:1] == '0)
  else $error("sc result is neither 0 nor 1");

endmodule

bind riscv_lsu riscv_lsu_chk riscv_lsu_chk_inst (
  .i_riscv_lsu_clk         (i_riscv_lsu_clk),
  .i_riscv_lsu_rst         (i_riscv_lsu_rst),
  .i_riscv_lsu_goto_trap   (i_riscv_lsu_goto_trap),
  .i_riscv_lsu_dcache_wren (o_riscv_lsu_dcache_wren),
  .i_riscv_lsu_dcache_rden (o_riscv_lsu_dcache_rden),
  .i_riscv_lsu_timer_wren  (o_riscv_lsu_timer_wren),
  .i_riscv_lsu_timer_rden  (o_riscv_lsu_timer_rden),
  .i_riscv_lsu_sc_rdvalue  (o_riscv_lsu_sc_rdvalue)
);

/* sim/riscv_lsu_tb.sv */
`timescale 1ns/100ps

module riscv_lsu_tb;

  import riscv_lsu_pkg::*;

  localparam int TIMEOUT_CYCLES = 400; // directed sequence needs about 90

  logic            clk;
  logic            rst;
  logic            globstall;
  logic [XLEN-1:0] address;      // rs1
  logic [XLEN-1:0] alu_result;
  logic [1:0]      lr;
  logic [1:0]      sc;
  logic            amo;
  logic            dcache_wren;
  logic            dcache_rden;
  logic            goto_trap;
  logic [1:0]      return_trap;
  logic            misalignment;
  logic [XLEN-1:0] store_data;
  logic [XLEN-1:0] wb_data;
  logic            wb_valid;
  logic            timer_irq;

  int seed = 32'h16fe_6732;
  int cycle_count = 0;

  riscv_lsu_mem_top riscv_lsu_mem_top_inst (
    .i_riscv_lsu_clk          (clk),
    .i_riscv_lsu_rst          (rst),
    .i_riscv_lsu_globstall    (globstall),
    .i_riscv_lsu_address      (address),
    .i_riscv_lsu_alu_result   (alu_result),
    .i_riscv_lsu_lr           (lr),
    .i_riscv_lsu_sc           (sc),
    .i_riscv_lsu_amo          (amo),
    .i_riscv_lsu_dcache_wren  (dcache_wren),
    .i_riscv_lsu_dcache_rden  (dcache_rden),
    .i_riscv_lsu_goto_trap    (goto_trap),
    .i_riscv_lsu_return_trap  (return_trap),
    .i_riscv_lsu_misalignment (misalignment),
    .i_riscv_lsu_store_data   (store_data),
    .o_riscv_lsu_wb_data      (wb_data),
    .o_riscv_lsu_wb_valid     (wb_valid),
    .o_riscv_lsu_timer_irq    (timer_irq)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES)
      fail_run("Timeout: the tests did not finish within the cycle limit");
  end

  task automatic expect_eq(input string test_name, input string what,
                           input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
    assert (actual === expected)
    else
      fail_run($sformatf("Mismatch in %s, %s: expected %h, actual %h",
                         test_name, what, expected, actual));
  endtask

  task automatic expect_bit(input string test_name, input string what,
                            input logic expected, input logic actual);
    assert (actual === expected)
    else
      fail_run($sformatf("Mismatch in %s, %s: expected %b, actual %b",
                         test_name, what, expected, actual));
  endtask

  // doubleword aligned byte address, well below the clint
  function automatic logic [XLEN-1:0] dword_addr(input logic [DMEM_ADDR_W-1:0] idx);
    return {{(XLEN-DMEM_ADDR_W-3){1'b0}}, idx, 3'b000};
  endfunction

  function automatic logic [XLEN-1:0] random_dword();
    return {$random(seed), $random(seed)};
  endfunction

  task automatic idle_inputs();
    globstall    = 1'b0;
    address      = '0;
    alu_result   = '0;
    lr           = 2'b00;
    sc           = 2'b00;
    amo          = 1'b0;
    dcache_wren  = 1'b0;
    dcache_rden  = 1'b0;
    goto_trap    = 1'b0;
    return_trap  = 2'b00;
    misalignment = 1'b0;
    store_data   = '0;
  endtask

  // request edge, then back to the falling edge where results are stable
  task automatic clock_request();
    @(posedge clk);
    @(negedge clk);
    idle_inputs();
  endtask

  task automatic store_dword(input string test_name, input logic [XLEN-1:0] addr,
                             input logic [XLEN-1:0] data);
    dcache_wren = 1'b1;
    alu_result  = addr;
    store_data  = data;
    clock_request();
    expect_bit(test_name, "store wb_valid", 1'b0, wb_valid);
  endtask

  task automatic load_dword(input string test_name, input logic [XLEN-1:0] addr,
                            input logic [XLEN-1:0] expected);
    dcache_rden = 1'b1;
    alu_result  = addr;
    clock_request();
    expect_bit(test_name, "load wb_valid", 1'b1, wb_valid);
    expect_eq(test_name, "load data", expected, wb_data);
  endtask

  task automatic load_reserved(input string test_name, input logic [XLEN-1:0] addr,
                               input logic size_d, input logic [XLEN-1:0] expected);
    lr         = {1'b1, size_d};
    address    = addr;
    alu_result = addr;
    clock_request();
    expect_bit(test_name, "lr wb_valid", 1'b1, wb_valid);
    expect_eq(test_name, "lr data", expected, wb_data);
  endtask

  // sc returns 0 when it stores, 1 when it fails
  task automatic store_conditional(input string test_name, input logic [XLEN-1:0] addr,
                                   input logic size_d, input logic [XLEN-1:0] data,
                                   input logic expect_fail);
    sc         = {1'b1, size_d};
    address    = addr;
    alu_result = addr;
    store_data = data;
    clock_request();
    expect_bit(test_name, "sc wb_valid", 1'b1, wb_valid);
    expect_eq(test_name, "sc result", {{(XLEN-1){1'b0}}, expect_fail}, wb_data);
  endtask

  task automatic test_store_load();
    logic [31:0]     rnd;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data;
    for (int i = 0; i < 16; i++)
    begin
      rnd  = $random(seed);
      addr = dword_addr(rnd[DMEM_ADDR_W-1:0]);
      data = random_dword();
      store_dword("store_load", addr, data);
      load_dword("store_load", addr, data);
    end
  endtask

  task automatic test_lr_sc();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] d;
    a = dword_addr(8'h20);
    x = random_dword();
    d = random_dword();
    store_dword("lr_sc", a, x);
    load_reserved("lr_sc", a, 1'b1, x);
    store_conditional("lr_sc", a, 1'b1, d, 1'b0);
    load_dword("lr_sc", a, d);
    store_conditional("lr_sc", a, 1'b1, x, 1'b1); // reservation already gone
    load_dword("lr_sc", a, d);
  endtask

  task automatic test_sc_mismatch();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] y;
    a = dword_addr(8'h40);
    b = dword_addr(8'h41);
    x = random_dword();
    y = random_dword();
    store_dword("sc_mismatch", a, x);
    store_dword("sc_mismatch", b, y);
    load_reserved("sc_mismatch", a, 1'b1, x);
    store_conditional("sc_mismatch", b, 1'b1, ~y, 1'b1);  // other address
    load_dword("sc_mismatch", b, y);
    load_reserved("sc_mismatch", a, 1'b0, x);             // word reservation
    store_conditional("sc_mismatch", a, 1'b1, ~x, 1'b1);
    load_dword("sc_mismatch", a, x);
    load_reserved("sc_mismatch", a, 1'b1, x);
    goto_trap = 1'b1;
    store_conditional("sc_mismatch", a, 1'b1, ~x, 1'b1);
    load_dword("sc_mismatch", a, x);
  endtask

  task automatic test_trap_access();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] y;
    a = dword_addr(8'h80);
    x = random_dword();
    y = random_dword();
    store_dword("trap_access", a, x);
    goto_trap = 1'b1;
    store_dword("trap_access", a, y);
    return_trap = 2'b01;
    store_dword("trap_access", a, y);
    return_trap = 2'b10;
    dcache_rden = 1'b1;
    alu_result  = a;
    clock_request();
    expect_bit("trap_access", "trapped load wb_valid", 1'b0, wb_valid);
    load_dword("trap_access", a, x);
  endtask

  task automatic test_timer();
    logic [31:0]     rnd;
    logic [XLEN-1:0] v;
    int              waited;
    rnd = $random(seed);
    v   = {32'd0, rnd};  // far from wrap
    store_dword("timer", CLINT_MTIME, v);
    load_dword("timer", CLINT_MTIME, v + 64'd1);
    store_dword("timer", CLINT_MTIMECMP, v + 64'd3);
    expect_bit("timer", "irq after mtimecmp write", 1'b0, timer_irq);
    load_dword("timer", CLINT_MTIMECMP, v + 64'd3);
    waited = 2;
    while (!timer_irq && waited < 5)
    begin
      @(negedge clk);
      waited++;
    end
    assert (timer_irq)
    else
      fail_run("Timer interrupt did not rise within 5 cycles of the mtimecmp write");
  endtask

  task automatic test_stall_reservation();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] x;
    logic [XLEN-1:0] d;
    a = dword_addr(8'hC0);
    x = random_dword();
    d = random_dword();
    store_dword("stall_reservation", a, x);
    load_reserved("stall_reservation", a, 1'b1, x);
    globstall = 1'b1;  // idle stalled cycle
    clock_request();
    expect_bit("stall_reservation", "stalled wb_valid", 1'b0, wb_valid);
    expect_eq("stall_reservation", "stalled wb_data held", x, wb_data); // lr result kept
    store_conditional("stall_reservation", a, 1'b1, d, 1'b0);
    load_dword("stall_reservation", a, d);
  endtask

  initial
  begin
    idle_inputs();
    rst = 1'b1;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    test_store_load();
    test_lr_sc();
    test_sc_mismatch();
    test_trap_access();
    test_timer();
    test_stall_reservation();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
